//--- hdl/mf2_pkg.sv
////////////////////////////////////////////////////////////////////////////
// shared constants and types for the Multiface Two add-on
// holds the snooped port codes, the shadow slot map inside the 8 KB RAM,
// the mode encoding and the gate array command decode
////////////////////////////////////////////////////////////////////////////

package mf2_pkg;

	// sizes
	localparam int cpu_addr_w = 16;
	localparam int mf2_addr_w = 13;
	localparam int mf2_depth  = 8192;
	localparam int data_w     = 8;

	// high address bytes of the snooped I/O ports
	localparam logic [7:0] port_ga       = 8'h7f;  // gate array
	localparam logic [7:0] port_crtc_sel = 8'hbc;
	localparam logic [7:0] port_crtc_val = 8'hbd;
	localparam logic [7:0] port_ppi      = 8'hf7;  // 8255
	localparam logic [7:0] port_rom_sel  = 8'hdf;  // upper rom select

	// FEE8h and FEEAh differ only in bit 1
	localparam logic [13:0] page_port_base = 14'h3fba;

	////////////////////////////////////////////////////////////////////////
	// shadow slots, fixed by the MF2 ROM software
	localparam logic [12:0] slot_pen       = 13'h1fcf;
	localparam logic [12:0] slot_border    = 13'h1fdf;
	localparam logic [12:0] slot_pen_base  = 13'h1f90;  // 16 ink entries
	localparam logic [12:0] slot_mode      = 13'h1fef;
	localparam logic [12:0] slot_bank      = 13'h1fff;
	localparam logic [12:0] slot_crtc_sel  = 13'h1cff;
	localparam logic [12:0] slot_crtc_base = 13'h1db0;  // 16 crtc registers
	localparam logic [12:0] slot_ppi       = 13'h17ff;
	localparam logic [12:0] slot_rom_sel   = 13'h1aac;

	// M1 fetch addresses
	localparam logic [15:0] nmi_entry_addr = 16'h0066;
	localparam logic [15:0] hide_addr      = 16'h0065;

	typedef enum logic [1:0] {
		mode_enabled  = 2'd0,
		mode_hidden   = 2'd1,
		mode_disabled = 2'd2
	} mf2_mode_e;

	// gate array command byte, pen select view and plain function view
	typedef union packed {
		struct packed {
			logic [1:0] func;
			logic       spare;
			logic [4:0] pen;
		} pen_sel;
		struct packed {
			logic [1:0] func;
			logic [5:0] payload;
		} raw;
	} ga_cmd_u;

endpackage

//--- hdl/cpu_bus_if.sv
////////////////////////////////////////////////////////////////////////////
// snooped Z80 bus as seen by the Multiface Two blocks
// driven from the top level ports, each block takes its own modport
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

interface cpu_bus_if ();
	import mf2_pkg::*;

	logic [cpu_addr_w-1:0] addr;
	logic [data_w-1:0]     data;    // cpu data out
	logic                  io_wr;
	logic                  mem_wr;
	logic                  mem_rd;
	logic                  m1;

	// I/O write decoder
	modport snoop (
		input addr,
		input data,
		input io_wr
	);

	// paging FSM only needs fetches
	modport pager (
		input addr,
		input m1
	);

	modport ram (
		input addr,
		input data,
		input mem_wr,
		input mem_rd
	);

endinterface

//--- hdl/mf2_io_snoop.sv
////////////////////////////////////////////////////////////////////////////
// I/O write snooper for the Multiface Two
// turns writes to the gate array, CRTC, 8255 and rom select ports into
// shadow RAM stores, and writes to FEE8h/FEEAh into page requests
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module mf2_io_snoop (
	input  logic                         clk_sys,
	input  logic                         reset,
	cpu_bus_if.snoop                     bus,
	output logic                         store_we,
	output logic [mf2_pkg::mf2_addr_w-1:0] store_addr,
	output logic [mf2_pkg::data_w-1:0]     store_data,
	output logic                         page_wr,
	output logic                         page_on
);
	import mf2_pkg::*;

	logic                  io_wr_q;
	logic [4:0]            pen_q;       // last selected pen
	logic [3:0]            crtc_sel_q;  // last crtc register index
	logic [mf2_addr_w-1:0] slot;
	ga_cmd_u               cmd;
	logic                  io_edge;
	logic                  is_page_port;

	assign cmd          = bus.data;
	assign io_edge      = bus.io_wr & ~io_wr_q;
	assign is_page_port = (bus.addr[15:2] == page_port_base);

	// slot for the current write, 0 means not shadowed
	always_comb begin
		case (bus.addr[15:8])
			port_ga: begin
				case (cmd.raw.func)
					2'b00:   slot = slot_pen;
					2'b01:   slot = pen_q[4] ? slot_border
						: slot_pen_base + {9'd0, pen_q[3:0]};
					2'b10:   slot = slot_mode;
					default: slot = slot_bank;
				endcase
			end
			port_crtc_sel: slot = slot_crtc_sel;
			port_crtc_val: slot = slot_crtc_base + {9'd0, crtc_sel_q};
			port_ppi:      slot = slot_ppi;
			port_rom_sel:  slot = slot_rom_sel;
			default:       slot = '0;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_wr_q    <= 1'b0;
			store_we   <= 1'b0;
			page_wr    <= 1'b0;
			pen_q      <= '0;
			crtc_sel_q <= '0;
		end else begin
			io_wr_q  <= bus.io_wr;
			store_we <= 1'b0;
			page_wr  <= 1'b0;
			if (io_edge && is_page_port) begin
				page_wr <= 1'b1;
			end else if (io_edge && slot != '0) begin
				store_we <= 1'b1;
				if (bus.addr[15:8] == port_ga && cmd.raw.func == 2'b00)
					pen_q <= cmd.pen_sel.pen;
				if (bus.addr[15:8] == port_crtc_sel)
					crtc_sel_q <= bus.data[3:0];
			end
		end
	end

	// payload follows the strobes above
	always_ff @(posedge clk_sys) begin
		if (io_edge) begin
			store_addr <= slot;
			store_data <= bus.data;
			page_on    <= ~bus.addr[1];  // FEE8h pages in, FEEAh out
		end
	end

endmodule

//--- hdl/mf2_ram_port.sv
////////////////////////////////////////////////////////////////////////////
// 8 KB Multiface Two RAM with a single registered port
// shadow stores take priority over CPU writes, otherwise the CPU address
// is registered for a read; dout is FF unless the CPU reads the window
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module mf2_ram_port (
	input  logic                           clk_sys,
	input  logic                           reset,
	cpu_bus_if.ram                         bus,
	input  logic                           ram_en,
	input  logic                           store_we,
	input  logic [mf2_pkg::mf2_addr_w-1:0] store_addr,
	input  logic [mf2_pkg::data_w-1:0]     store_data,
	output logic [mf2_pkg::data_w-1:0]     dout
);
	import mf2_pkg::*;

	logic [data_w-1:0]     mem [mf2_depth];

	logic                  cpu_wr;
	logic [mf2_addr_w-1:0] cpu_a;

	// registered port request
	logic                  ram_we;
	logic [mf2_addr_w-1:0] ram_a;
	logic [data_w-1:0]     ram_din;
	logic [data_w-1:0]     ram_q;

	assign cpu_wr = bus.mem_wr & ram_en;
	assign cpu_a  = bus.addr[mf2_addr_w-1:0];  // window offset inside 2000h-3FFFh

	////////////////////////////////////////////////////////////////////////
	// arbiter

	always_ff @(posedge clk_sys) begin
		if (reset)
			ram_we <= 1'b0;
		else
			ram_we <= store_we | cpu_wr;
	end

	always_ff @(posedge clk_sys) begin
		if (store_we) begin
			ram_a   <= store_addr;    // hw register shadow wins
			ram_din <= store_data;
		end else if (cpu_wr) begin
			ram_a   <= cpu_a;
			ram_din <= bus.data;
		end else begin
			ram_a   <= cpu_a;         // read
		end
	end

	////////////////////////////////////////////////////////////////////////
	// array, write-through on the output register

	always_ff @(posedge clk_sys) begin
		if (ram_we) begin
			mem[ram_a] <= ram_din;
			ram_q      <= ram_din;
		end else begin
			ram_q <= mem[ram_a];
		end
	end

	// open bus reads as FF, ANDed with the other sources on the CPC side
	assign dout = (bus.mem_rd & ram_en) ? ram_q : 8'hff;

endmodule

//--- hdl/mf2_paging.sv
////////////////////////////////////////////////////////////////////////////
// Multiface Two paging control
// raises NMI from the front-panel key, pages the ROM/RAM in at the 0066h
// fetch, handles hiding at 0065h and the FEE8h/FEEAh page ports
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module mf2_paging (
	input  logic               clk_sys,
	input  logic               reset,
	cpu_bus_if.pager           bus,
	input  logic               key_nmi,
	input  mf2_pkg::mf2_mode_e mf2_mode,
	input  logic               page_wr,
	input  logic               page_on,
	output logic               nmi,
	output logic               active,
	output logic               rom_en,
	output logic               ram_en
);
	import mf2_pkg::*;

	logic key_nmi_q;
	logic m1_q;
	logic hidden;     // page ports ignored until next NMI entry
	logic key_rise;
	logic m1_rise;
	logic allowed;

	assign key_rise = key_nmi & ~key_nmi_q;
	assign m1_rise  = bus.m1 & ~m1_q;
	assign allowed  = (mf2_mode != mode_disabled);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			key_nmi_q <= 1'b0;
			m1_q      <= 1'b0;
		end else begin
			key_nmi_q <= key_nmi;
			m1_q      <= bus.m1;
		end
	end

	////////////////////////////////////////////////////////////////////////
	// nmi / active / hidden
	// later statements take priority, page port writes last

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			nmi    <= 1'b0;
			active <= 1'b0;
			hidden <= (mf2_mode != mode_enabled);
		end else begin
			if (key_rise && !active && allowed)
				nmi <= 1'b1;

			// NMI vector fetch, MF2 ROM takes over
			if (m1_rise && nmi && bus.addr == nmi_entry_addr) begin
				active <= 1'b1;
				hidden <= 1'b0;
				nmi    <= 1'b0;
			end

			if (m1_rise && active && bus.addr == hide_addr)
				hidden <= 1'b1;

			if (page_wr)
				active <= page_on & ~hidden & allowed;
		end
	end

	////////////////////////////////////////////////////////////////////////
	// windows in the lower 16 KB

	assign rom_en = active & (bus.addr[15:13] == 3'b000);  // 0000h-1FFFh
	assign ram_en = active & (bus.addr[15:13] == 3'b001);  // 2000h-3FFFh

endmodule

//--- hdl/multiface_two.sv
////////////////////////////////////////////////////////////////////////////
// Multiface Two add-on for the CPC bus
// takes the CPU bus and key as plain ports, returns the RAM read data,
// the NMI request and the ROM/RAM window enables for the memory mux
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module multiface_two (
	input  logic                           clk_sys,
	input  logic                           reset,
	input  logic [mf2_pkg::cpu_addr_w-1:0] cpu_addr,
	input  logic [mf2_pkg::data_w-1:0]     cpu_dout,
	input  logic                           io_wr,
	input  logic                           mem_wr,
	input  logic                           mem_rd,
	input  logic                           m1,
	input  logic                           key_nmi,
	input  mf2_pkg::mf2_mode_e             mf2_mode,
	output logic [mf2_pkg::data_w-1:0]     dout,
	output logic                           nmi,
	output logic                           active,
	output logic                           rom_en,
	output logic                           ram_en
);
	import mf2_pkg::*;

	logic                  store_we;
	logic [mf2_addr_w-1:0] store_addr;
	logic [data_w-1:0]     store_data;
	logic                  page_wr;
	logic                  page_on;

	cpu_bus_if bus ();

	assign bus.addr   = cpu_addr;
	assign bus.data   = cpu_dout;
	assign bus.io_wr  = io_wr;
	assign bus.mem_wr = mem_wr;
	assign bus.mem_rd = mem_rd;
	assign bus.m1     = m1;

	////////////////////////////////////////////////////////////////////////

	mf2_io_snoop mf2_io_snoop_i (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.bus        (bus.snoop),
		.store_we   (store_we),
		.store_addr (store_addr),
		.store_data (store_data),
		.page_wr    (page_wr),
		.page_on    (page_on)
	);

	mf2_paging mf2_paging_i (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.bus      (bus.pager),
		.key_nmi  (key_nmi),
		.mf2_mode (mf2_mode),
		.page_wr  (page_wr),
		.page_on  (page_on),
		.nmi      (nmi),
		.active   (active),
		.rom_en   (rom_en),
		.ram_en   (ram_en)
	);

	// ram_en also gates CPU writes and reads inside the RAM block
	mf2_ram_port mf2_ram_port_i (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.bus        (bus.ram),
		.ram_en     (ram_en),
		.store_we   (store_we),
		.store_addr (store_addr),
		.store_data (store_data),
		.dout       (dout)
	);

endmodule

//--- tb/mf2_sva.sv
////////////////////////////////////////////////////////////////////////////
// concurrent checks on the Multiface Two paging outputs
// bound into every mf2_paging instance, failures counted in fail_count
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module mf2_sva (
	input logic clk_sys,
	input logic reset,
	input logic page_wr,
	input logic page_on,
	input logic hidden,
	input logic nmi,
	input logic active,
	input logic rom_en,
	input logic ram_en
);
	int unsigned fail_count = 0;  // read by the testbench at the end

	// a page-out write closes both windows on the next edge
	page_out_closes: assert property (@(posedge clk_sys) disable iff (reset)
		page_wr && !page_on |=> !rom_en && !ram_en)
		else begin
			$error("rom_en or ram_en still high after a page-out write");
			fail_count++;
		end

	// hidden MF2 ignores the page ports
	hidden_blocks_page_in: assert property (@(posedge clk_sys) disable iff (reset)
		page_wr && hidden |=> !active)
		else begin
			$error("page port write paged in while hidden");
			fail_count++;
		end

	no_nmi_when_active: assert property (@(posedge clk_sys) disable iff (reset)
		!(nmi && active))
		else begin
			$error("nmi set while active is high");
			fail_count++;
		end

endmodule

bind mf2_paging mf2_sva mf2_sva_i (.clk_sys, .reset, .page_wr, .page_on, .hidden, .nmi,
	.active, .rom_en, .ram_en);

//--- tb/mf2_checker.sv
////////////////////////////////////////////////////////////////////////////
// testbench checker for the Multiface Two
// keeps a model of the 8 KB RAM and compares dout and the paging outputs
// against the expectations that the stimulus hands over
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module mf2_checker (
	input  logic        clk_sys,
	input  logic [15:0] cpu_addr,
	input  logic [7:0]  dout,
	input  logic        nmi,
	input  logic        active,
	input  logic        rom_en,
	input  logic        ram_en,
	input  logic        model_we,     // expected RAM update
	input  logic [12:0] model_addr,
	input  logic [7:0]  model_data,
	input  logic        check_state,  // compare paging outputs this cycle
	input  logic        check_read,   // compare dout this cycle
	input  logic        exp_nmi,
	input  logic        exp_active,
	output int          errors
);
	logic [7:0] model [8192];
	logic       exp_rom;
	logic       exp_ram;
	logic [7:0] exp_dout;
	int         err_count = 0;

	assign exp_rom  = exp_active && cpu_addr[15:13] == 3'd0;
	assign exp_ram  = exp_active && cpu_addr[15:13] == 3'd1;
	assign exp_dout = exp_ram ? model[cpu_addr[12:0]] : 8'hff;  // open bus otherwise
	assign errors   = err_count;

	task automatic compare(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			err_count++;
			$display("ERROR %s: got %h expected %h (addr %h)", name, got, exp, cpu_addr);
		end
	endtask

	always @(posedge clk_sys) begin
		if (model_we)
			model[model_addr] <= model_data;
	end

	// mid-cycle sampling, inputs move 5 ns after the rising edge
	always @(negedge clk_sys) begin
		if (check_state) begin
			compare("nmi", nmi, exp_nmi);
			compare("active", active, exp_active);
			compare("rom_en", rom_en, exp_rom);
			compare("ram_en", ram_en, exp_ram);
		end
		if (check_read) begin
			compare("ram_en", ram_en, exp_ram);
			compare("dout", dout, exp_dout);
		end
	end

endmodule

//--- tb/tb_multiface_two.sv
////////////////////////////////////////////////////////////////////////////
// testbench for the Multiface Two add-on
// drives CPU bus cycles and the NMI key, mf2_checker does the comparing
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_multiface_two;
	import mf2_pkg::*;

	localparam int n_shadow   = 40;
	localparam int n_cpu      = 30;
	localparam int op_cycles  = 4;
	// each random op is written and read back, ~60 fixed ops, 5x margin
	localparam int max_cycles = 5 * op_cycles * (2 * n_shadow + 2 * n_cpu + 60);

	typedef enum {op_io, op_wr, op_rd, op_m1, op_key} op_e;

	logic        clk_sys;
	logic        reset;
	logic [15:0] cpu_addr;
	logic [7:0]  cpu_dout;
	logic        io_wr;
	logic        mem_wr;
	logic        mem_rd;
	logic        m1;
	logic        key_nmi;
	mf2_mode_e   mf2_mode;
	logic [7:0]  dout;
	logic        nmi;
	logic        active;
	logic        rom_en;
	logic        ram_en;
	logic        model_we;
	logic [12:0] model_addr;
	logic [7:0]  model_data;
	logic        check_state;
	logic        check_read;
	logic        exp_nmi;
	logic        exp_active;
	int          errors;
	int          cycles = 0;
	logic [4:0]  pen_t;   // pen as the CPU last selected it
	logic [3:0]  crtc_t;

	multiface_two multiface_two_i (.*);
	mf2_checker mf2_checker_i (.*);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	// shadow slot for an I/O write, 0 when the port is not shadowed
	function automatic logic [12:0] mf2_expected_slot(input logic [7:0] port,
		input logic [7:0] d, input logic [4:0] pen, input logic [3:0] crtc);
		case (port)
			8'h7f: begin
				case (d[7:6])
					2'b00:   return slot_pen;
					2'b01:   return pen[4] ? slot_border : slot_pen_base + pen[3:0];
					2'b10:   return slot_mode;
					default: return slot_bank;
				endcase
			end
			8'hbc:   return slot_crtc_sel;
			8'hbd:   return slot_crtc_base + crtc;
			8'hf7:   return slot_ppi;
			8'hdf:   return slot_rom_sel;
			default: return 13'h0;
		endcase
	endfunction

	// one bus access held for 3 cycles, dout checked in the last one
	task automatic bus_op(input logic [15:0] a, input logic [7:0] d, input op_e kind);
		@(posedge clk_sys);
		#5;
		cpu_addr = a;
		cpu_dout = d;
		io_wr    = (kind == op_io);
		mem_wr   = (kind == op_wr);
		mem_rd   = (kind == op_rd);
		m1       = (kind == op_m1);
		key_nmi  = (kind == op_key);
		repeat (2) @(posedge clk_sys);
		#5;
		check_read = mem_rd;
		@(posedge clk_sys);
		#5;
		{io_wr, mem_wr, mem_rd, m1, key_nmi, check_read, model_we} = '0;
	endtask

	task automatic io_write(input logic [15:0] a, input logic [7:0] d);
		model_addr = mf2_expected_slot(a[15:8], d, pen_t, crtc_t);
		model_data = d;
		model_we   = (model_addr != 13'h0);
		if (a[15:8] == 8'h7f && d[7:6] == 2'b00)
			pen_t = d[4:0];
		if (a[15:8] == 8'hbc)
			crtc_t = d[3:0];
		bus_op(a, d, op_io);
	endtask

	task automatic mem_write(input logic [15:0] a, input logic [7:0] d);
		model_addr = a[12:0];
		model_data = d;
		model_we   = exp_active && a[15:13] == 3'd1;  // only inside the RAM window
		bus_op(a, d, op_wr);
	endtask

	task automatic check_at(input logic [15:0] a);
		@(posedge clk_sys);
		#5;
		cpu_addr    = a;
		check_state = 1'b1;
		@(posedge clk_sys);
		#5;
		check_state = 1'b0;
	endtask

	initial begin
		logic [7:0]  ports [5];
		logic [7:0]  ga_seq [6];
		logic [15:0] wr_addr [$];
		logic [15:0] a;
		int          total;

		void'($urandom(1309));
		ports  = '{port_ga, port_crtc_sel, port_crtc_val, port_ppi, port_rom_sel};
		ga_seq = '{8'h10, 8'h5c, 8'h05, 8'h63, 8'h8d, 8'hc2};
		reset    = 1'b1;
		mf2_mode = mode_enabled;
		{cpu_addr, cpu_dout, io_wr, mem_wr, mem_rd, m1, key_nmi} = '0;
		{model_we, model_addr, model_data, check_state, check_read} = '0;
		{exp_nmi, exp_active, pen_t, crtc_t} = '0;
		repeat (8) @(posedge clk_sys);
		#5;
		reset = 1'b0;

		// reset state, every read is open bus
		check_at(16'h0000);
		check_at(16'h2000);
		bus_op(16'h2abc, 8'h00, op_rd);
		bus_op(16'h0123, 8'h00, op_rd);

		////////////////////////////////////////////////////////////////////
		// NMI entry and the lower 16 KB windows
		bus_op(16'h0000, 8'h00, op_key);
		exp_nmi = 1'b1;
		check_at(16'h0000);
		bus_op(nmi_entry_addr, 8'h00, op_m1);
		exp_nmi    = 1'b0;
		exp_active = 1'b1;
		check_at(16'h0000);
		check_at(16'h1fff);
		check_at(16'h2000);
		check_at(16'h3fff);
		check_at(16'h4000);

		// all four gate array functions, border pen and an ink pen
		foreach (ga_seq[i]) begin
			io_write(16'h7f00, ga_seq[i]);
			bus_op({3'b001, model_addr}, 8'h00, op_rd);
		end

		// hardware shadowing, read back each slot right after the write
		for (int i = 0; i < n_shadow; i++) begin
			io_write({ports[$urandom_range(4)], 8'($urandom)}, 8'($urandom));
			bus_op({3'b001, model_addr}, 8'h00, op_rd);
		end

		////////////////////////////////////////////////////////////////////
		// CPU RAM path
		for (int i = 0; i < n_cpu; i++) begin
			a = {3'b001, 13'($urandom)};
			wr_addr.push_back(a);
			mem_write(a, 8'($urandom));
		end
		foreach (wr_addr[i])
			bus_op(wr_addr[i], 8'h00, op_rd);
		bus_op(16'h4000 | 16'($urandom_range(16'h3fff)), 8'h00, op_rd);
		bus_op(16'h0100, 8'h00, op_rd);  // rom window, RAM stays off

		// page ports and hiding
		io_write(16'hfeea, 8'h00);
		exp_active = 1'b0;
		check_at(16'h2000);
		bus_op(wr_addr[0], 8'h00, op_rd);
		io_write(16'hfee8, 8'h00);
		exp_active = 1'b1;
		check_at(16'h2000);
		bus_op(hide_addr, 8'h00, op_m1);
		io_write(16'hfeea, 8'h00);
		exp_active = 1'b0;
		io_write(16'hfee8, 8'h00);
		check_at(16'h2000);

		mf2_mode = mode_disabled;
		bus_op(16'h0000, 8'h00, op_key);
		check_at(16'h0000);

		repeat (2) @(posedge clk_sys);
		total = errors + multiface_two_i.mf2_paging_i.mf2_sva_i.fail_count;
		$display("errors: %0d (checker %0d, assertions %0d)", total, errors,
			multiface_two_i.mf2_paging_i.mf2_sva_i.fail_count);
		if (total == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles == max_cycles) begin
			$display("timeout: run did not finish within %0d cycles", max_cycles);
			$display("errors: %0d", errors);
			$display("Test failures found");
			$finish;
		end
	end

endmodule

//--- multiface_two.f
hdl/mf2_pkg.sv
hdl/cpu_bus_if.sv
hdl/mf2_io_snoop.sv
hdl/mf2_ram_port.sv
hdl/mf2_paging.sv
hdl/multiface_two.sv
tb/mf2_sva.sv
tb/mf2_checker.sv
tb/tb_multiface_two.sv

//--- Bender.yml
package:
  name: multiface_two

sources:
  - files:
      - hdl/mf2_pkg.sv
      - hdl/cpu_bus_if.sv
      - hdl/mf2_io_snoop.sv
      - hdl/mf2_ram_port.sv
      - hdl/mf2_paging.sv
      - hdl/multiface_two.sv
  - target: test
    files:
      - tb/mf2_sva.sv
      - tb/mf2_checker.sv
      - tb/tb_multiface_two.sv
